// ==== proc_settings.svh ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// processor settings: data width, register count, nop encoding
// and the program counter value after reset
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef PROC_SETTINGS_SVH
`define PROC_SETTINGS_SVH

// data and instruction width
`define PROC_DATA_W 16

// general purpose registers
`define PROC_REG_CNT 8

// nop word, also what flushed slots carry
`define PROC_NOP_INST 16'h0800

`define PROC_RESET_PC 16'h0000

`endif

// ==== proc_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// processor package: word and register types, opcode and alu enums,
// result state enum, decode-to-execute and execute-to-result structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "proc_settings.svh"

package proc_pkg;

  typedef logic [`PROC_DATA_W-1:0] word_t;
  typedef logic [2:0] reg_idx_t;

  // opcode lives in inst[15:11]
  //   reg-reg : rs 10:8, rt 7:5, rd 4:2, func 1:0 (00 add, 01 sub, 10 xor, 11 andn)
  //   i-format: rs 10:8, rd 7:5, imm5 4:0
  //   lbi     : dest 10:8, imm8 7:0, sign extended
  // sub is second operand minus first (rt - rs, imm - rs)
  // andn is a & ~b
  // addi/subi sign extend imm5, xori/andni zero extend it
  // shift and rotate amount is imm[3:0]
  typedef enum logic [4:0] {
    OP_HALT   = 5'b00000,
    OP_NOP    = 5'b00001,
    OP_ADDI   = 5'b01000,
    OP_SUBI   = 5'b01001,
    OP_XORI   = 5'b01010,
    OP_ANDNI  = 5'b01011,
    OP_ROLI   = 5'b10100,
    OP_SLLI   = 5'b10101,
    OP_RORI   = 5'b10110,
    OP_SRLI   = 5'b10111,
    OP_LBI    = 5'b11000,
    OP_ALU_RR = 5'b11011
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_ANDN,
    ALU_ROL,
    ALU_SLL,
    ALU_ROR,
    ALU_SRL,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic {
    ST_RUNNING,
    ST_HALTED
  } run_state_t;

  typedef struct packed {
    logic     valid;
    alu_op_t  alu_op;
    reg_idx_t rs;
    logic     use_rs;
    reg_idx_t rt;
    logic     use_rt;
    reg_idx_t dest;
    logic     reg_write;
    logic     use_imm;
    word_t    imm;
    logic     halt;
    logic     illegal;
    word_t    a;
    word_t    b;
  } ex_ctrl_t;

  typedef struct packed {
    logic     valid;
    logic     reg_write;
    reg_idx_t dest;
    word_t    data;
    logic     halt;
    logic     illegal;
  } wb_t;

endpackage

`default_nettype wire

// ==== fetch_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// fetch stage: program counter, instruction register, halt freeze
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "proc_settings.svh"

module fetch_stage import proc_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  halt_seen,
  output word_t      inst_addr,
  input  wire word_t inst_data,
  output word_t      fetch_inst
);

  word_t pc;
  logic  frozen;
  logic  hold;

  // halt in decode stops fetch this cycle, frozen keeps it stopped
  assign hold      = halt_seen | frozen;
  assign inst_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc         <= `PROC_RESET_PC;
      frozen     <= 1'b0;
      fetch_inst <= `PROC_NOP_INST;
    end else begin
      if (halt_seen) begin
        frozen <= 1'b1;
      end
      // byte addressed, two bytes per instruction
      if (!hold) begin
        pc <= pc + word_t'(2);
      end
      // the slot behind the halt turns into a nop
      if (hold) begin
        fetch_inst <= `PROC_NOP_INST;
      end else begin
        fetch_inst <= inst_data;
      end
    end
  end

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// decode stage: field split, immediate extension, alu function,
// register reads and the decode-to-execute register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "proc_settings.svh"

module decode_stage import proc_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire word_t fetch_inst,
  output reg_idx_t   rd_idx_a,
  output reg_idx_t   rd_idx_b,
  input  wire word_t rd_data_a,
  input  wire word_t rd_data_b,
  output logic       halt_seen,
  output ex_ctrl_t   ex_ctrl
);

  opcode_t  opcode;
  word_t    imm5_sext;
  word_t    imm5_zext;
  word_t    imm8_sext;
  ex_ctrl_t ctrl_next;

  assign opcode = opcode_t'(fetch_inst[15:11]);

  assign imm5_sext = {{(`PROC_DATA_W-5){fetch_inst[4]}}, fetch_inst[4:0]};
  assign imm5_zext = {{(`PROC_DATA_W-5){1'b0}}, fetch_inst[4:0]};
  assign imm8_sext = {{(`PROC_DATA_W-8){fetch_inst[7]}}, fetch_inst[7:0]};

  // both read ports always look at the same bit fields
  assign rd_idx_a = fetch_inst[10:8];
  assign rd_idx_b = fetch_inst[7:5];

  always_comb begin
    ctrl_next       = '0;
    ctrl_next.valid = 1'b1;
    ctrl_next.rs    = fetch_inst[10:8];
    ctrl_next.rt    = fetch_inst[7:5];
    ctrl_next.a     = rd_data_a;
    ctrl_next.b     = rd_data_b;
    case (opcode)
      OP_NOP: begin
        ctrl_next.valid = 1'b0;
      end
      OP_HALT: begin
        ctrl_next.halt = 1'b1;
      end
      OP_ALU_RR: begin
        ctrl_next.use_rs    = 1'b1;
        ctrl_next.use_rt    = 1'b1;
        ctrl_next.dest      = fetch_inst[4:2];
        ctrl_next.reg_write = 1'b1;
        case (fetch_inst[1:0])
          2'b00:   ctrl_next.alu_op = ALU_ADD;
          2'b01:   ctrl_next.alu_op = ALU_SUB;
          2'b10:   ctrl_next.alu_op = ALU_XOR;
          default: ctrl_next.alu_op = ALU_ANDN;
        endcase
      end
      OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI, OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI: begin
        ctrl_next.use_rs    = 1'b1;
        ctrl_next.use_imm   = 1'b1;
        ctrl_next.dest      = fetch_inst[7:5];
        ctrl_next.reg_write = 1'b1;
        // logic ops zero extend, the rest sign extend
        if (opcode == OP_XORI || opcode == OP_ANDNI) begin
          ctrl_next.imm = imm5_zext;
        end else begin
          ctrl_next.imm = imm5_sext;
        end
        case (opcode)
          OP_ADDI:  ctrl_next.alu_op = ALU_ADD;
          OP_SUBI:  ctrl_next.alu_op = ALU_SUB;
          OP_XORI:  ctrl_next.alu_op = ALU_XOR;
          OP_ANDNI: ctrl_next.alu_op = ALU_ANDN;
          OP_ROLI:  ctrl_next.alu_op = ALU_ROL;
          OP_SLLI:  ctrl_next.alu_op = ALU_SLL;
          OP_RORI:  ctrl_next.alu_op = ALU_ROR;
          default:  ctrl_next.alu_op = ALU_SRL;
        endcase
      end
      OP_LBI: begin
        ctrl_next.use_imm   = 1'b1;
        ctrl_next.imm       = imm8_sext;
        ctrl_next.dest      = fetch_inst[10:8];
        ctrl_next.reg_write = 1'b1;
        ctrl_next.alu_op    = ALU_PASS_B;
      end
      default: begin
        // unknown opcode, carried along only to raise err
        ctrl_next.illegal = 1'b1;
      end
    endcase
  end

  assign halt_seen = ctrl_next.halt;

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_ctrl <= '0;
    end else begin
      ex_ctrl <= ctrl_next;
    end
  end

endmodule

`default_nettype wire

// ==== register_file.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// register file: eight words, two read ports, one write port,
// same-cycle write visible on the read ports
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "proc_settings.svh"

module register_file import proc_pkg::*; (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire reg_idx_t rd_idx_a,
  input  wire reg_idx_t rd_idx_b,
  output word_t         rd_data_a,
  output word_t         rd_data_b,
  input  wire logic     wr_en,
  input  wire reg_idx_t wr_idx,
  input  wire word_t    wr_data
);

  word_t regs [`PROC_REG_CNT];

  always_ff @(posedge clk) begin
    if (reset) begin
      regs <= '{default: '0};
    end else if (wr_en) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // write-through, so decode sees the result written this cycle
  assign rd_data_a = (wr_en && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
  assign rd_data_b = (wr_en && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

`default_nettype wire

// ==== execute_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// execute stage: operand forwarding from the result stage, the alu
// and the execute-to-result register
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "proc_settings.svh"

module execute_stage import proc_pkg::*; (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire ex_ctrl_t ex_ctrl,
  input  wire logic     fwd_en,
  input  wire reg_idx_t fwd_idx,
  input  wire word_t    fwd_data,
  output wb_t           wb
);

  word_t                     op_a;
  word_t                     op_b;
  word_t                     src_b;
  logic [3:0]                amt;
  logic [2*`PROC_DATA_W-1:0] rot_l;
  logic [2*`PROC_DATA_W-1:0] rot_r;
  word_t                     alu_out;
  wb_t                       wb_next;

  // take the result-stage value when it writes our source register
  function automatic word_t fwd_sel(input logic used, input reg_idx_t idx,
                                    input word_t read_val);
    if (used && fwd_en && fwd_idx == idx) begin
      return fwd_data;
    end
    return read_val;
  endfunction

  always_comb begin
    op_a = fwd_sel(ex_ctrl.use_rs, ex_ctrl.rs, ex_ctrl.a);
    op_b = fwd_sel(ex_ctrl.use_rt, ex_ctrl.rt, ex_ctrl.b);
  end

  assign src_b = ex_ctrl.use_imm ? ex_ctrl.imm : op_b;

  assign amt = src_b[3:0];

  // doubled word makes rotates plain shifts
  assign rot_l = {op_a, op_a} << amt;
  assign rot_r = {op_a, op_a} >> amt;

  always_comb begin
    case (ex_ctrl.alu_op)
      ALU_ADD:    alu_out = op_a + src_b;
      ALU_SUB:    alu_out = src_b - op_a;
      ALU_XOR:    alu_out = op_a ^ src_b;
      ALU_ANDN:   alu_out = op_a & ~src_b;
      ALU_ROL:    alu_out = rot_l[2*`PROC_DATA_W-1:`PROC_DATA_W];
      ALU_SLL:    alu_out = op_a << amt;
      ALU_ROR:    alu_out = rot_r[`PROC_DATA_W-1:0];
      ALU_SRL:    alu_out = op_a >> amt;
      ALU_PASS_B: alu_out = src_b;
      default:    alu_out = '0;
    endcase
  end

  always_comb begin
    wb_next.valid     = ex_ctrl.valid;
    wb_next.reg_write = ex_ctrl.valid & ex_ctrl.reg_write;
    wb_next.dest      = ex_ctrl.dest;
    wb_next.data      = alu_out;
    wb_next.halt      = ex_ctrl.halt;
    wb_next.illegal   = ex_ctrl.illegal;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb <= '0;
    end else begin
      wb <= wb_next;
    end
  end

endmodule

`default_nettype wire

// ==== result_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// result stage: register write, halted fsm, err pulse
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module result_stage import proc_pkg::*; (
  input  wire logic clk,
  input  wire logic reset,
  input  wire wb_t  wb,
  output logic      wr_en,
  output reg_idx_t  wr_idx,
  output word_t     wr_data,
  output logic      halted,
  output logic      err
);

  run_state_t state;
  run_state_t state_next;
  logic       halt_now;

  assign halt_now = wb.valid & wb.halt;

  always_comb begin
    state_next = state;
    if (state == ST_RUNNING && halt_now) begin
      state_next = ST_HALTED;
    end
  end

  // only reset leaves the halted state
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ST_RUNNING;
    end else begin
      state <= state_next;
    end
  end

  assign wr_en   = wb.valid & wb.reg_write & (state == ST_RUNNING);
  assign wr_idx  = wb.dest;
  assign wr_data = wb.data;

  // halted already shows in the halt's own result cycle
  assign halted = halt_now | (state == ST_HALTED);
  assign err    = wb.valid & wb.illegal;

endmodule

`default_nettype wire

// ==== proc.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// processor top: fetch, decode with register file, execute, result
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module proc import proc_pkg::*; (
  input  wire logic  clk,
  input  wire logic  reset,
  output word_t      inst_addr,
  input  wire word_t inst_data,
  output logic       wb_en,
  output reg_idx_t   wb_reg,
  output word_t      wb_data,
  output logic       halted,
  output logic       err
);

  word_t    fetch_inst;
  logic     halt_seen;
  reg_idx_t rd_idx_a;
  reg_idx_t rd_idx_b;
  word_t    rd_data_a;
  word_t    rd_data_b;
  ex_ctrl_t ex_ctrl;
  wb_t      wb;

  fetch_stage u_fetch (
    .clk        (clk),
    .reset      (reset),
    .halt_seen  (halt_seen),
    .inst_addr  (inst_addr),
    .inst_data  (inst_data),
    .fetch_inst (fetch_inst)
  );

  decode_stage u_decode (
    .clk        (clk),
    .reset      (reset),
    .fetch_inst (fetch_inst),
    .rd_idx_a   (rd_idx_a),
    .rd_idx_b   (rd_idx_b),
    .rd_data_a  (rd_data_a),
    .rd_data_b  (rd_data_b),
    .halt_seen  (halt_seen),
    .ex_ctrl    (ex_ctrl)
  );

  register_file u_regs (
    .clk       (clk),
    .reset     (reset),
    .rd_idx_a  (rd_idx_a),
    .rd_idx_b  (rd_idx_b),
    .rd_data_a (rd_data_a),
    .rd_data_b (rd_data_b),
    .wr_en     (wb_en),
    .wr_idx    (wb_reg),
    .wr_data   (wb_data)
  );

  // register write doubles as the forwarding source
  execute_stage u_execute (
    .clk      (clk),
    .reset    (reset),
    .ex_ctrl  (ex_ctrl),
    .fwd_en   (wb_en),
    .fwd_idx  (wb_reg),
    .fwd_data (wb_data),
    .wb       (wb)
  );

  result_stage u_result (
    .clk     (clk),
    .reset   (reset),
    .wb      (wb),
    .wr_en   (wb_en),
    .wr_idx  (wb_reg),
    .wr_data (wb_data),
    .halted  (halted),
    .err     (err)
  );

endmodule

`default_nettype wire

// ==== proc_asserts.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// processor assertions: reset, halt and err behaviour, bound to proc
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module proc_asserts import proc_pkg::*; (
  input wire logic  clk,
  input wire logic  reset,
  input wire word_t inst_addr,
  input wire logic  wb_en,
  input wire logic  halted,
  input wire logic  err
);

  // pipeline registers are cleared by reset
  wb_quiet_after_reset: assert property (@(posedge clk) reset |=> !wb_en)
    else $error("wb_en high in the cycle after reset");

  halted_sticky: assert property (@(posedge clk) disable iff (reset) halted |=> halted)
    else $error("halted fell without a reset");

  // pc is frozen once the halt has been decoded
  addr_frozen: assert property (@(posedge clk) disable iff (reset)
                                halted |=> $stable(inst_addr))
    else $error("inst_addr moved while halted");

  err_no_write: assert property (@(posedge clk) !(err && wb_en))
    else $error("err and wb_en high in the same cycle");

endmodule

bind proc proc_asserts u_asserts (
  .clk       (clk),
  .reset     (reset),
  .inst_addr (inst_addr),
  .wb_en     (wb_en),
  .halted    (halted),
  .err       (err)
);

`default_nettype wire

// ==== proc_tb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// processor testbench: instruction memory, reference model,
// directed tests and compare tasks
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

`include "proc_settings.svh"

module proc_tb import proc_pkg::*; ();

  // five programs of under 40 words need a few hundred cycles in all
  localparam int MAX_CYCLES = 2000;

  typedef struct packed {
    reg_idx_t idx;
    word_t    data;
  } wr_event_t;

  logic     clk;
  logic     reset;
  word_t    inst_addr;
  word_t    inst_data;
  logic     wb_en;
  reg_idx_t wb_reg;
  word_t    wb_data;
  logic     halted;
  logic     err;

  word_t       imem [64];
  word_t       model_regs [8];
  wr_event_t   expected [$];
  int          prog_len;
  logic        model_halted;
  word_t       frozen_addr;
  logic [31:0] rng_state = 32'h95af_7238;
  string       cur_test;
  int          checks = 0;
  int          errors = 0;
  int          cycle_count = 0;
  opcode_t     imm_ops [8] = '{OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI,
                               OP_ROLI, OP_SLLI, OP_RORI, OP_SRLI};

  proc UUT (.*);

  // halfword addressed program memory
  assign inst_data = imem[inst_addr[6:1]];

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic word_t rr_word(input reg_idx_t rs, input reg_idx_t rt,
                                    input reg_idx_t rd, input logic [1:0] fn);
    return {OP_ALU_RR, rs, rt, rd, fn};
  endfunction

  function automatic word_t imm_word(input opcode_t op, input reg_idx_t rs,
                                     input reg_idx_t rd, input logic [4:0] imm5);
    return {op, rs, rd, imm5};
  endfunction

  function automatic word_t lbi_word(input reg_idx_t rd, input logic [7:0] imm8);
    return {OP_LBI, rd, imm8};
  endfunction

  function automatic word_t halt_word();
    return {OP_HALT, 11'h000};
  endfunction

  task automatic compare_word(input string what, input word_t exp, input word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  task automatic compare_reg(input string what, input reg_idx_t exp, input reg_idx_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s %s: expected r%0d, actual r%0d", cur_test, what, exp, act);
    end
  endtask

  task automatic compare_bit(input string what, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
    end
  endtask

  // reference model built from the encoding rules
  task automatic model_inst(input word_t inst);
    word_t      a;
    word_t      b;
    word_t      res;
    word_t      imm_s;
    word_t      imm_z;
    logic [3:0] amt;
    reg_idx_t   dest;
    logic       writes;
    wr_event_t  ev;
    a      = model_regs[inst[10:8]];
    b      = model_regs[inst[7:5]];
    imm_s  = {{11{inst[4]}}, inst[4:0]};
    imm_z  = {11'h000, inst[4:0]};
    amt    = inst[3:0];
    dest   = inst[7:5];
    writes = 1'b1;
    res    = '0;
    case (inst[15:11])
      OP_ALU_RR: begin
        dest = inst[4:2];
        case (inst[1:0])
          2'b00:   res = a + b;
          2'b01:   res = b - a;
          2'b10:   res = a ^ b;
          default: res = a & ~b;
        endcase
      end
      OP_ADDI:  res = a + imm_s;
      OP_SUBI:  res = imm_s - a;
      OP_XORI:  res = a ^ imm_z;
      OP_ANDNI: res = a & ~imm_z;
      OP_ROLI:  res = (a << amt) | (a >> (5'd16 - {1'b0, amt}));
      OP_SLLI:  res = a << amt;
      OP_RORI:  res = (a >> amt) | (a << (5'd16 - {1'b0, amt}));
      OP_SRLI:  res = a >> amt;
      OP_LBI: begin
        dest = inst[10:8];
        res  = {{8{inst[7]}}, inst[7:0]};
      end
      // halt, nop and unknown opcodes write nothing
      default: writes = 1'b0;
    endcase
    if (writes) begin
      model_regs[dest] = res;
      ev.idx  = dest;
      ev.data = res;
      expected.push_back(ev);
    end
  endtask

  // lbi fill makes any word fetched past the halt show as a write
  task automatic start_program();
    for (int i = 0; i < 64; i++) begin
      imem[i] = lbi_word(i[2:0], {2'b01, i[5:0]});
    end
    for (int i = 0; i < 8; i++) begin
      model_regs[i] = '0;
    end
    expected.delete();
    prog_len     = 0;
    model_halted = 1'b0;
    frozen_addr  = `PROC_RESET_PC;
  endtask

  task automatic put_inst(input word_t inst);
    imem[prog_len] = inst;
    prog_len++;
    if (!model_halted) begin
      model_inst(inst);
      // fetch stops on the word after the halt
      if (inst[15:11] == OP_HALT) begin
        frozen_addr = word_t'(`PROC_RESET_PC + 2 * prog_len);
      end
    end
    if (inst[15:11] == OP_HALT) begin
      model_halted = 1'b1;
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
  endtask

  task automatic run_program(input logic exp_err, input int hold);
    wr_event_t got [$];
    wr_event_t ev;
    logic      halted_seen;
    int        hold_left;
    int        err_pulses;
    int        errors_before;
    errors_before = errors;
    err_pulses    = 0;
    halted_seen   = 1'b0;
    hold_left     = hold;
    apply_reset();
    compare_word("inst_addr after reset", `PROC_RESET_PC, inst_addr);
    compare_bit("wb_en after reset", 1'b0, wb_en);
    compare_bit("halted after reset", 1'b0, halted);
    compare_bit("err after reset", 1'b0, err);
    while (hold_left > 0) begin
      @(negedge clk);
      if (err) begin
        err_pulses++;
      end
      if (wb_en) begin
        ev.idx  = wb_reg;
        ev.data = wb_data;
        got.push_back(ev);
      end
      if (halted_seen) begin
        compare_bit("halted held", 1'b1, halted);
        compare_word("inst_addr held", frozen_addr, inst_addr);
        hold_left--;
      end else if (halted) begin
        halted_seen = 1'b1;
        compare_word("inst_addr at halt", frozen_addr, inst_addr);
      end
    end
    if (got.size() != expected.size()) begin
      errors++;
      $display("%s: expected %0d writebacks but saw %0d", cur_test, expected.size(),
               got.size());
    end
    for (int i = 0; i < got.size() && i < expected.size(); i++) begin
      compare_reg("wb_reg", expected[i].idx, got[i].idx);
      compare_word("wb_data", expected[i].data, got[i].data);
    end
    compare_bit("err seen", exp_err, err_pulses != 0);
    if (err_pulses > 1) begin
      errors++;
      $display("%s: err pulsed %0d times for a single bad opcode", cur_test, err_pulses);
    end
    $display("%-8s %0d writebacks, %s", cur_test, got.size(),
             (errors == errors_before) ? "ok" : "failed");
  endtask

  task automatic reset_state_test();
    cur_test = "reset";
    start_program();
    put_inst(halt_word());
    run_program(1'b0, 4);
  endtask

  task automatic reg_reg_test();
    logic [31:0] r;
    reg_idx_t    prev;
    cur_test = "reg_reg";
    start_program();
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      put_inst(lbi_word(i[2:0], r[7:0]));
    end
    prev = 3'd7;
    // previous result alternates between rs and rt
    for (int i = 0; i < 16; i++) begin
      r = next_rand();
      if (i[0]) begin
        put_inst(rr_word(r[8:6], prev, r[5:3], i[1:0]));
      end else begin
        put_inst(rr_word(prev, r[8:6], r[5:3], i[1:0]));
      end
      prev = r[5:3];
    end
    put_inst(halt_word());
    run_program(1'b0, 4);
  endtask

  task automatic imm_test();
    logic [31:0] r;
    reg_idx_t    prev;
    cur_test = "imm";
    start_program();
    for (int i = 0; i < 8; i++) begin
      r = next_rand();
      put_inst(lbi_word(i[2:0], r[7:0]));
    end
    prev = 3'd0;
    for (int i = 0; i < 24; i++) begin
      r = next_rand();
      put_inst(imm_word(imm_ops[i[2:0]], i[0] ? r[10:8] : prev, r[2:0], r[7:3]));
      prev = r[2:0];
    end
    put_inst(halt_word());
    run_program(1'b0, 4);
  endtask

  task automatic halt_test();
    cur_test = "halt";
    start_program();
    put_inst(lbi_word(3'd1, 8'h5a));
    put_inst(imm_word(OP_ADDI, 3'd1, 3'd2, 5'h13));
    put_inst(halt_word());
    put_inst(imm_word(OP_XORI, 3'd2, 3'd3, 5'h0f));
    put_inst(lbi_word(3'd4, 8'h81));
    run_program(1'b0, 12);
  endtask

  task automatic illegal_test();
    cur_test = "illegal";
    start_program();
    put_inst(lbi_word(3'd1, 8'hc4));
    put_inst(imm_word(OP_ADDI, 3'd1, 3'd2, 5'h05));
    // opcode 00110 is unused
    put_inst({5'b00110, 3'd2, 3'd6, 5'h01});
    put_inst(imm_word(OP_SUBI, 3'd2, 3'd3, 5'h1e));
    put_inst(rr_word(3'd2, 3'd3, 3'd4, 2'b00));
    put_inst(halt_word());
    run_program(1'b1, 4);
  endtask

  initial begin
    clk   = 1'b0;
    reset = 1'b1;
    reset_state_test();
    reg_reg_test();
    imm_test();
    halt_test();
    illegal_test();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
proc_pkg.sv
fetch_stage.sv
decode_stage.sv
register_file.sv
execute_stage.sv
result_stage.sv
proc.sv
proc_asserts.sv
proc_tb.sv

// ==== Makefile ====
# Verilator build and run of the processor testbench

TOP = proc_tb

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -Mdir obj_dir -o sim

run: compile
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir

.PHONY: all compile run clean
